// File: vlog.f
design/arith_cfg_pkg.sv
design/arith_ops_pkg.sv
design/compare_unit.sv
design/mul_unit.sv
design/nr_divider.sv
design/arith_unit.sv
bench/arith_unit_checker.sv
bench/arith_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module arith_unit_tb --Mdir obj_dir -o arith_unit_sim \
	-f vlog.f

# the simulator status is not trusted, the log decides
./obj_dir/arith_unit_sim 2>&1 | tee sim.log

if grep -qx "sim passed" sim.log; then
	echo "simulation ok"
else
	echo "simulation did not pass"
	exit 1
fi

// File: bench/arith_unit_tb.sv
`timescale 1ns/100ps

module arith_unit_tb;

	import arith_cfg_pkg::*;
	import arith_ops_pkg::*;

	localparam int NUM_TESTS      = 200;
	localparam int RANDOM_PER_OP  = 40;
	// a divide with DIV_STEPS_PER_CYCLE of 2 stays well under 40 cycles
	localparam int TIMEOUT_CYCLES = NUM_TESTS * 40 + 500;
	// edges from the accept edge to the edge that raises done
	localparam int CMP_LATENCY    = 1;
	localparam int MUL_LATENCY    = 3;

	// what one accepted command must come back with
	// latency of 0 means not checked
	typedef struct packed
	{
		arith_result_t res;
		int            latency;
		int            accept_cnt;
	} expect_t;

	logic          clk;
	logic          rst;
	arith_cmd_t    cmd;
	logic          cmd_enable;
	logic          ready;
	logic          done;
	arith_result_t result;

	int      seed;
	int      cycle_cnt = 0;
	int      error_cnt = 0;
	int      check_cnt = 0;
	expect_t exp_q[$];
	expect_t exp_head;

	arith_unit
	#(
		.DIV_STEPS_PER_CYCLE (2)
	)
	u_arith_unit
	(
		.clk        (clk),
		.rst        (rst),
		.cmd        (cmd),
		.cmd_enable (cmd_enable),
		.ready      (ready),
		.done       (done),
		.result     (result)
	);

	always #50 clk = ~clk;

	// expected value and rem straight from the operation rules
	function automatic arith_result_t model_result(input arith_cmd_t c);
		arith_result_t           r;
		logic [2*WORD_WIDTH-1:0] prod;
		r = '0;
		case (c.op)
			OP_CMP:
			begin
				r.value[0] = (c.a < c.b);
				r.value[1] = ($signed(c.a) < $signed(c.b));
			end
			OP_MUL:
			begin
				prod    = {{WORD_WIDTH{1'b0}}, c.a} * {{WORD_WIDTH{1'b0}}, c.b};
				r.value = prod[WORD_WIDTH-1:0];
			end
			OP_DIVU:
			begin
				// divide by zero gives all ones and the numerator back
				if (c.b == '0)
				begin
					r.value = '1;
					r.rem   = c.a;
				end
				else
				begin
					r.value = c.a / c.b;
					r.rem   = c.a % c.b;
				end
			end
			default:
			begin
				// truncation toward zero and rem with the numerator's sign
				r.value = $signed(c.a) / $signed(c.b);
				r.rem   = $signed(c.a) % $signed(c.b);
			end
		endcase
		return r;
	endfunction

	function automatic arith_cmd_t make_cmd(input arith_op_t op, input word_t a, input word_t b);
		arith_cmd_t c;
		c.op = op;
		c.a  = a;
		c.b  = b;
		return c;
	endfunction

	// divisor with a random magnitude so quotients spread out
	function automatic word_t random_divisor();
		word_t d;
		int    sh;
		d  = $random(seed);
		sh = $random(seed) & 31;
		return d >> sh;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_cnt++;
		if (actual !== expected)
		begin
			$display("error %s: got %h, expected %h", name, actual, expected);
			error_cnt++;
		end
	endtask

	task automatic record_accept(input arith_cmd_t c, input int latency);
		expect_t e;
		e.res        = model_result(c);
		e.latency    = latency;
		e.accept_cnt = cycle_cnt;
		exp_q.push_back(e);
	endtask

	// one command with enable dropped right at the accept edge
	task automatic issue_cmd(input arith_cmd_t c, input int latency);
		while (!ready)
			@(negedge clk);
		@(posedge clk);
		cmd        <= c;
		cmd_enable <= 1'b1;
		@(posedge clk);
		cmd_enable <= 1'b0;
		@(negedge clk);
		record_accept(c, latency);
	endtask

	task automatic random_signed_divide();
		word_t a;
		word_t b;
		a = $random(seed);
		b = random_divisor();
		if ($random(seed) & 1)
			b = -b;
		// keep clear of zero divisors and the overflow pair
		if (b == '0)
			b = 32'd5;
		if (a == 32'h8000_0000 && b == '1)
			b = 32'd9;
		issue_cmd(make_cmd(OP_DIVS, a, b), 0);
	endtask

	// enable stays high with a second command while busy
	task automatic hold_enable_while_busy(input arith_cmd_t first, input arith_cmd_t second);
		while (!ready)
			@(negedge clk);
		@(posedge clk);
		cmd        <= first;
		cmd_enable <= 1'b1;
		@(posedge clk);
		// first taken here while second sits on the bus
		cmd <= second;
		@(negedge clk);
		record_accept(first, MUL_LATENCY);
		while (!ready)
			@(negedge clk);
		// ready comes back only together with done
		check_value("done", 32'(done), 32'd1);
		@(posedge clk);
		cmd_enable <= 1'b0;
		@(negedge clk);
		record_accept(second, CMP_LATENCY);
	endtask

	// compare side sampled away from the active edge
	always @(negedge clk)
	begin
		if (!rst && done)
		begin
			if (exp_q.size() == 0)
			begin
				$display("done pulsed while no command was in flight");
				error_cnt++;
			end
			else
			begin
				exp_head = exp_q.pop_front();
				check_value("result.value", result.value, exp_head.res.value);
				check_value("result.rem", result.rem, exp_head.res.rem);
				if (exp_head.latency != 0)
					check_value("done latency", 32'(cycle_cnt - exp_head.accept_cnt),
						32'(exp_head.latency));
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("sim failed");
			$finish;
		end
	end

	initial
	begin
		clk        = 1'b0;
		rst        = 1'b1;
		cmd        = '0;
		cmd_enable = 1'b0;
		seed       = 32'hd296fbb2;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value("ready", 32'(ready), 32'd1);
		check_value("done", 32'(done), 32'd0);
		check_value("result.value", result.value, 32'd0);
		check_value("result.rem", result.rem, 32'd0);

		// the first compare also times the path out of reset
		issue_cmd(make_cmd(OP_CMP, 32'd3, 32'd9), CMP_LATENCY);
		issue_cmd(make_cmd(OP_CMP, 32'd0, 32'd0), CMP_LATENCY);
		issue_cmd(make_cmd(OP_CMP, 32'h1234_5678, 32'h1234_5678), CMP_LATENCY);
		issue_cmd(make_cmd(OP_CMP, 32'hffff_ffff, 32'hffff_ffff), CMP_LATENCY);
		issue_cmd(make_cmd(OP_CMP, 32'h0000_0000, 32'hffff_ffff), CMP_LATENCY);
		issue_cmd(make_cmd(OP_CMP, 32'hffff_ffff, 32'h0000_0000), CMP_LATENCY);
		issue_cmd(make_cmd(OP_CMP, 32'h7fff_ffff, 32'h8000_0000), CMP_LATENCY);
		issue_cmd(make_cmd(OP_CMP, 32'h8000_0000, 32'h7fff_ffff), CMP_LATENCY);
		issue_cmd(make_cmd(OP_CMP, 32'h8000_0000, 32'h8000_0000), CMP_LATENCY);
		issue_cmd(make_cmd(OP_CMP, 32'hffff_ffff, 32'h0000_0001), CMP_LATENCY);
		for (int i = 0; i < RANDOM_PER_OP; i++)
			issue_cmd(make_cmd(OP_CMP, $random(seed), $random(seed)), CMP_LATENCY);

		// multiply edges then random words
		issue_cmd(make_cmd(OP_MUL, 32'hffff_ffff, 32'hffff_ffff), MUL_LATENCY);
		issue_cmd(make_cmd(OP_MUL, 32'h0000_0000, 32'hdead_beef), MUL_LATENCY);
		issue_cmd(make_cmd(OP_MUL, 32'h8000_0000, 32'h0000_0002), MUL_LATENCY);
		issue_cmd(make_cmd(OP_MUL, 32'h0000_ffff, 32'h0000_ffff), MUL_LATENCY);
		issue_cmd(make_cmd(OP_MUL, 32'h0001_0000, 32'h0001_0000), MUL_LATENCY);
		issue_cmd(make_cmd(OP_MUL, 32'h7fff_ffff, 32'h7fff_ffff), MUL_LATENCY);
		for (int i = 0; i < RANDOM_PER_OP; i++)
			issue_cmd(make_cmd(OP_MUL, $random(seed), $random(seed)), MUL_LATENCY);

		// unsigned divide including zero divisors
		issue_cmd(make_cmd(OP_DIVU, 32'hdead_beef, 32'h0000_0000), 0);
		issue_cmd(make_cmd(OP_DIVU, 32'h0000_0000, 32'h0000_0000), 0);
		issue_cmd(make_cmd(OP_DIVU, 32'hffff_ffff, 32'h0000_0001), 0);
		issue_cmd(make_cmd(OP_DIVU, 32'h0000_0005, 32'h0000_0007), 0);
		issue_cmd(make_cmd(OP_DIVU, 32'h1234_5678, 32'h1234_5678), 0);
		issue_cmd(make_cmd(OP_DIVU, 32'hffff_ffff, 32'h8000_0000), 0);
		for (int i = 0; i < RANDOM_PER_OP; i++)
			issue_cmd(make_cmd(OP_DIVU, $random(seed), random_divisor()), 0);

		// signed divide over all four sign pairs
		issue_cmd(make_cmd(OP_DIVS, 32'd100, 32'd7), 0);
		issue_cmd(make_cmd(OP_DIVS, -32'd100, 32'd7), 0);
		issue_cmd(make_cmd(OP_DIVS, 32'd100, -32'd7), 0);
		issue_cmd(make_cmd(OP_DIVS, -32'd100, -32'd7), 0);
		issue_cmd(make_cmd(OP_DIVS, 32'h7fff_ffff, 32'hffff_ffff), 0);
		for (int i = 0; i < RANDOM_PER_OP; i++)
			random_signed_divide();

		hold_enable_while_busy(make_cmd(OP_MUL, 32'h0001_2345, 32'h0006_789a),
			make_cmd(OP_CMP, 32'h8000_0000, 32'h0000_0001));

		// drain what is still in flight
		while (exp_q.size() != 0)
			@(negedge clk);
		// handshake assertion failures count as errors
		error_cnt = error_cnt + u_arith_unit.u_arith_unit_checker.fail_cnt;
		$display("checks: %0d, errors: %0d", check_cnt, error_cnt);
		if (error_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: bench/arith_unit_checker.sv
`timescale 1ns/100ps

module arith_unit_checker
(
	input logic clk,
	input logic rst,
	input logic cmd_enable,
	input logic ready,
	input logic done
);

	// accepted command whose done is still owed
	logic pending;

	// number of failed assertions
	int fail_cnt = 0;

	always_ff @(posedge clk)
	begin
		if (rst)
			pending <= 1'b0;
		else if (cmd_enable && ready)
			pending <= 1'b1;
		else if (done)
			pending <= 1'b0;
	end

	// single cycle pulse
	done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else
		begin
			$error("done stayed high for more than one cycle");
			fail_cnt = fail_cnt + 1;
		end

	done_with_ready: assert property (@(posedge clk) disable iff (rst) done |-> ready)
		else
		begin
			$error("done high while ready low");
			fail_cnt = fail_cnt + 1;
		end

	// busy right after an accept
	ready_drops: assert property (@(posedge clk) disable iff (rst) (cmd_enable && ready) |=> !ready)
		else
		begin
			$error("ready still high after an accept");
			fail_cnt = fail_cnt + 1;
		end

	done_needs_cmd: assert property (@(posedge clk) disable iff (rst) done |-> pending)
		else
		begin
			$error("done without an accepted command");
			fail_cnt = fail_cnt + 1;
		end

endmodule

bind arith_unit arith_unit_checker u_arith_unit_checker
(
	.clk        (clk),
	.rst        (rst),
	.cmd_enable (cmd_enable),
	.ready      (ready),
	.done       (done)
);

// File: design/arith_unit.sv
`timescale 1ns/100ps

module arith_unit
#(
	parameter int DIV_STEPS_PER_CYCLE = 1
)
(
	input  logic                         clk,
	input  logic                         rst,
	input  arith_ops_pkg::arith_cmd_t    cmd,
	input  logic                         cmd_enable,
	output logic                         ready,
	output logic                         done,
	output arith_ops_pkg::arith_result_t result
);

	import arith_cfg_pkg::*;
	import arith_ops_pkg::*;

	// one command in flight
	logic busy;
	logic accept;
	logic finish;
	arith_op_t op_q;

	// operands held for the sequential units
	word_t a_q;
	word_t b_q;

	cmp_flags_t cmp_flags;
	cmp_flags_t cmp_q;

	// start pulses land one cycle after the accept
	logic mul_start;
	logic div_start;
	logic mul_done;
	logic div_done;
	word_t mul_product;
	word_t div_quot;
	word_t div_rem;

	arith_result_t next_result;

	assign ready  = !busy;
	assign accept = cmd_enable && ready;
	// compare finishes on the first busy cycle, the others wait for their unit
	assign finish = busy && ((op_q == OP_CMP) || mul_done || div_done);

	compare_unit u_compare_unit
	(
		.a     (cmd.a),
		.b     (cmd.b),
		.flags (cmp_flags)
	);

	mul_unit u_mul_unit
	(
		.clk     (clk),
		.rst     (rst),
		.start   (mul_start),
		.a       (a_q),
		.b       (b_q),
		.done    (mul_done),
		.product (mul_product)
	);

	nr_divider
	#(
		.DIV_STEPS_PER_CYCLE (DIV_STEPS_PER_CYCLE)
	)
	u_nr_divider
	(
		.clk       (clk),
		.rst       (rst),
		.start     (div_start),
		.is_signed (op_q == OP_DIVS),
		.num       (a_q),
		.denom     (b_q),
		.done      (div_done),
		.quot      (div_quot),
		.rem       (div_rem)
	);

	// result word by the accepted opcode
	always_comb
	begin
		case (op_q)
			OP_CMP:
			begin
				// lts in bit 1, ltu in bit 0
				next_result.value = {{(WORD_WIDTH - 2){1'b0}}, cmp_q.lts, cmp_q.ltu};
				next_result.rem   = '0;
			end
			OP_MUL:
			begin
				next_result.value = mul_product;
				next_result.rem   = '0;
			end
			default:
			begin
				next_result.value = div_quot;
				next_result.rem   = div_rem;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy      <= 1'b0;
			done      <= 1'b0;
			op_q      <= OP_CMP;
			mul_start <= 1'b0;
			div_start <= 1'b0;
			result    <= '0;
		end
		else
		begin
			done      <= finish;
			mul_start <= accept && (cmd.op == OP_MUL);
			div_start <= accept && ((cmd.op == OP_DIVU) || (cmd.op == OP_DIVS));
			if (accept)
			begin
				busy <= 1'b1;
				op_q <= cmd.op;
			end
			else if (finish)
				busy <= 1'b0;
			// result holds until the next finish
			if (finish)
				result <= next_result;
		end
	end

	// operands and flags captured at the accept
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			a_q   <= cmd.a;
			b_q   <= cmd.b;
			cmp_q <= cmp_flags;
		end
	end

endmodule

// File: design/nr_divider.sv
`timescale 1ns/100ps

module nr_divider
#(
	parameter int DIV_STEPS_PER_CYCLE = 1
)
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  logic                 is_signed,
	input  arith_cfg_pkg::word_t num,
	input  arith_cfg_pkg::word_t denom,
	output logic                 done,
	output arith_cfg_pkg::word_t quot,
	output arith_cfg_pkg::word_t rem
);

	import arith_cfg_pkg::*;

	// partial remainder needs one sign bit above twice the word
	localparam int REM_WIDTH = 2 * WORD_WIDTH + 1;

	typedef enum logic [1:0]
	{
		DIV_IDLE,
		DIV_SETUP,
		DIV_STEP,
		DIV_FIX
	} div_state_t;

	// only even splits of the word into cycles
	if (!(DIV_STEPS_PER_CYCLE == 1 || DIV_STEPS_PER_CYCLE == 2 || DIV_STEPS_PER_CYCLE == 4))
	begin : g_bad_steps
		$error("nr_divider: DIV_STEPS_PER_CYCLE must be 1, 2 or 4");
	end

	div_state_t state;
	logic [STEP_CNT_WIDTH-1:0] step_cnt;

	// operand signs, already gated by is_signed
	logic num_neg_in;
	logic den_neg_in;
	logic num_neg;
	logic den_neg;
	word_t num_mag;
	word_t den_mag;

	// partial remainder, shifted divisor and +1/-1 digit bits
	logic [REM_WIDTH-1:0] p_rem;
	logic [REM_WIDTH-1:0] p_next;
	logic [REM_WIDTH-1:0] d_shift;
	logic [REM_WIDTH-1:0] rem_full;
	word_t q_digits;
	word_t q_next;
	word_t q_bin;
	word_t quot_mag;
	word_t rem_mag;

	assign num_neg_in = is_signed && num[WORD_WIDTH-1];
	assign den_neg_in = is_signed && denom[WORD_WIDTH-1];
	assign d_shift    = {1'b0, den_mag, {WORD_WIDTH{1'b0}}};

	// one cycle's worth of non-restoring steps
	// digit 1 when the remainder is non-negative, else digit -1 stored as 0
	always_comb
	begin
		p_next = p_rem;
		q_next = q_digits;
		for (int i = 0; i < DIV_STEPS_PER_CYCLE; i++)
		begin
			if (!p_next[REM_WIDTH-1])
			begin
				q_next = {q_next[WORD_WIDTH-2:0], 1'b1};
				p_next = (p_next << 1) - d_shift;
			end
			else
			begin
				q_next = {q_next[WORD_WIDTH-2:0], 1'b0};
				p_next = (p_next << 1) + d_shift;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= DIV_IDLE;
			step_cnt <= '0;
		end
		else
		begin
			case (state)
				DIV_IDLE:
				begin
					// take magnitudes, remember what was negative
					if (start)
					begin
						num_neg <= num_neg_in;
						den_neg <= den_neg_in;
						num_mag <= num_neg_in ? -num : num;
						den_mag <= den_neg_in ? -denom : denom;
						state   <= DIV_SETUP;
					end
				end
				DIV_SETUP:
				begin
					p_rem    <= {{(WORD_WIDTH + 1){1'b0}}, num_mag};
					q_digits <= '0;
					step_cnt <= STEP_CNT_WIDTH'(WORD_WIDTH);
					state    <= DIV_STEP;
				end
				DIV_STEP:
				begin
					p_rem    <= p_next;
					q_digits <= q_next;
					step_cnt <= step_cnt - STEP_CNT_WIDTH'(DIV_STEPS_PER_CYCLE);
					if (step_cnt == STEP_CNT_WIDTH'(DIV_STEPS_PER_CYCLE))
						state <= DIV_FIX;
				end
				default:
					state <= DIV_IDLE;
			endcase
		end
	end

	// fix stage, sampled by the parent while in DIV_FIX
	always_comb
	begin
		// digits in {-1,+1} to two's complement
		q_bin    = q_digits - ~q_digits;
		rem_full = p_rem;
		// negative final remainder: one too many, restore once
		if (p_rem[REM_WIDTH-1])
		begin
			q_bin    = q_bin - 1'b1;
			rem_full = p_rem + d_shift;
		end
		quot_mag = q_bin;
		rem_mag  = rem_full[2*WORD_WIDTH-1:WORD_WIDTH];

		// divide by zero: all ones and the numerator back
		if (den_mag == '0)
		begin
			quot_mag = '1;
			rem_mag  = num_mag;
		end

		// truncate toward zero, remainder follows the numerator
		quot = (num_neg ^ den_neg) ? -quot_mag : quot_mag;
		rem  = num_neg ? -rem_mag : rem_mag;
	end

	assign done = (state == DIV_FIX);

endmodule

// File: design/mul_unit.sv
`timescale 1ns/100ps

module mul_unit
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  arith_cfg_pkg::word_t a,
	input  arith_cfg_pkg::word_t b,
	output logic                 done,
	output arith_cfg_pkg::word_t product
);

	import arith_cfg_pkg::*;

	typedef enum logic [1:0]
	{
		MUL_IDLE,
		MUL_PART,
		MUL_SUM
	} mul_state_t;

	mul_state_t state;

	// operands held for the whole operation
	word_t a_q;
	word_t b_q;

	// low x low needs the full word
	word_t p_lo;
	// cross terms land at bit HALF_WIDTH, only their low halves survive
	logic [HALF_WIDTH-1:0] p_mid0;
	logic [HALF_WIDTH-1:0] p_mid1;
	logic [HALF_WIDTH-1:0] mid_sum;

	// high x high would start at bit 32, so it is never formed
	always_ff @(posedge clk)
	begin
		if (rst)
			state <= MUL_IDLE;
		else
		begin
			case (state)
				MUL_IDLE:
				begin
					if (start)
					begin
						a_q   <= a;
						b_q   <= b;
						state <= MUL_PART;
					end
				end
				MUL_PART:
				begin
					// three products side by side
					p_lo   <= a_q[HALF_WIDTH-1:0] * b_q[HALF_WIDTH-1:0];
					p_mid0 <= a_q[HALF_WIDTH-1:0] * b_q[WORD_WIDTH-1:HALF_WIDTH];
					p_mid1 <= a_q[WORD_WIDTH-1:HALF_WIDTH] * b_q[HALF_WIDTH-1:0];
					state  <= MUL_SUM;
				end
				default:
					state <= MUL_IDLE;
			endcase
		end
	end

	// final sum is taken by the parent at the end of MUL_SUM
	always_comb
	begin
		mid_sum = p_mid0 + p_mid1;
		product = {mid_sum, {HALF_WIDTH{1'b0}}} + p_lo;
	end

	assign done = (state == MUL_SUM);

endmodule

// File: design/compare_unit.sv
`timescale 1ns/100ps

module compare_unit
(
	input  arith_cfg_pkg::word_t       a,
	input  arith_cfg_pkg::word_t       b,
	output arith_ops_pkg::cmp_flags_t  flags
);

	import arith_cfg_pkg::*;

	// carry out of a + ~b + 1
	logic  carry;
	// a - b, low word
	word_t diff;

	always_comb
	begin
		// subtract by adding the complement plus one
		{carry, diff} = {1'b0, a} + {1'b0, ~b} + {{WORD_WIDTH{1'b0}}, 1'b1};

		// no carry out means a borrow, so a < b unsigned
		flags.ltu = ~carry;

		// sign of the difference, flipped when the subtraction overflowed
		// overflow only if operand signs differ and the result sign left a's
		flags.lts = diff[WORD_WIDTH-1]
			^ ((a[WORD_WIDTH-1] ^ b[WORD_WIDTH-1])
			& (a[WORD_WIDTH-1] ^ diff[WORD_WIDTH-1]));
	end

endmodule

// File: design/arith_ops_pkg.sv
package arith_ops_pkg;

	// operation select
	// the two divide codes differ only in sign handling
	typedef enum logic [1:0]
	{
		OP_CMP,
		OP_MUL,
		OP_DIVU,
		OP_DIVS
	} arith_op_t;

	// one command as presented on the input side
	// 2 + 32 + 32 = 66 bits
	typedef struct packed
	{
		arith_op_t           op;
		arith_cfg_pkg::word_t a;
		arith_cfg_pkg::word_t b;
	} arith_cmd_t;

	// compare outcome
	// unsigned and signed less-than of a against b
	typedef struct packed
	{
		logic ltu;
		logic lts;
	} cmp_flags_t;

	// result word pair
	// value carries flags, product or quotient
	// rem is only nonzero for divides
	typedef struct packed
	{
		arith_cfg_pkg::word_t value;
		arith_cfg_pkg::word_t rem;
	} arith_result_t;

endpackage

// File: design/arith_cfg_pkg.sv
package arith_cfg_pkg;

	// operand and result width
	// the multiplier split and the divider remainder are sized from this
	localparam int WORD_WIDTH = 32;

	// one slice of the multiplier's partial products
	localparam int HALF_WIDTH = WORD_WIDTH / 2;

	// divider step counter
	// must hold the full step count WORD_WIDTH, so 6 bits for 32
	localparam int STEP_CNT_WIDTH = 6;

	// one operand or result word
	typedef logic [WORD_WIDTH-1:0] word_t;

endpackage
